//--- Bender.yml
package:
  name: branch_amend

sources:
  - include_dirs:
      - include
    files:
      - hw/branchTypesPkg.sv
      - hw/pipeTypesPkg.sv
      - hw/branchResolve.sv
      - hw/branchAmendStage.sv
      - hw/redirectControl.sv
      - hw/branchAmendTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/amendChecker.sv
      - tests/tbBranchAmend.sv

//--- flist.f
+incdir+include
hw/branchTypesPkg.sv
hw/pipeTypesPkg.sv
hw/branchResolve.sv
hw/branchAmendStage.sv
hw/redirectControl.sv
hw/branchAmendTop.sv
tests/amendChecker.sv
tests/tbBranchAmend.sv

//--- hw/branchAmendStage.sv
////////////////////////////////////////////////////////////////////////////
// pre-memory branch confirmation stage
// registers the resolved entry, interlocks against memory risk and
// raises the branch flush for a confirmed misprediction
////////////////////////////////////////////////////////////////////////////

module branchAmendStage
    import branchTypesPkg::*;
    import pipeTypesPkg::*;
(
    input  logic    clk,
    input  logic    rstN_i,
    // from upper execute
    input  logic    exeValid_i,
    input  exeOut_t exeData_i,
    output logic    allowin_o,
    // interlock and exception
    input  logic    memRisk_i,     // risk reported by the memory stage
    input  logic    excOccur_i,    // exception flush, clears everything
    // downstream side
    input  logic    outAllowin_i,
    output logic    valid_o,
    output exeOut_t data_o,
    // branch repair
    output logic    flush_o,
    output logic    hasRisk_o
);

    logic    hasData;
    exeOut_t held;
    logic    ready;
    logic    okToChange;
    logic    needFlush;
    logic    needUpdate;
    logic    needClear;
    logic    heldRepair;

    assign heldRepair = hasData && held.repair.needRepair;

    ////////////////////////////////////////////////////////////////////////////
    // interlock
    ////////////////////////////////////////////////////////////////////////////
    // a repair must wait until memory has no pending risk
    assign ready = !(memRisk_i && heldRepair);

    // misprediction confirmed, unless this entry itself faults
    assign flush_o = heldRepair && !held.hasException && !memRisk_i;

    // flushing entry leaves even when downstream is blocked
    assign valid_o   = hasData && ready && !excOccur_i && (outAllowin_i || flush_o);
    assign allowin_o = !hasData || (ready && outAllowin_i);

    assign okToChange = allowin_o;
    assign needFlush  = excOccur_i || flush_o;
    assign needUpdate = okToChange && exeValid_i && !needFlush;
    assign needClear  = (okToChange && !exeValid_i) || needFlush;

    // for the downstream interlock
    assign hasRisk_o = (hasData && (held.hasException || held.repair.needRepair)) ||
                       memRisk_i;

    ////////////////////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN_i || needClear) begin
            hasData <= 1'b0;
        end else if (needUpdate) begin
            hasData <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (needUpdate) begin
            held <= exeData_i;   // payload only moves with hasData
        end
    end

    assign data_o = held;

endmodule

//--- hw/branchAmendTop.sv
////////////////////////////////////////////////////////////////////////////
// branch confirmation slice: upper execute, pre-memory amend stage and
// the front end redirect, chained by valid/allowin
////////////////////////////////////////////////////////////////////////////

module branchAmendTop
    import branchTypesPkg::*;
    import pipeTypesPkg::*;
(
    input  logic      clk,
    input  logic      rstN_i,
    // instruction input
    input  logic      inValid_i,
    input  exeIn_t    inData_i,
    output logic      inAllowin_o,
    // memory stage and exception unit
    input  logic      memRisk_i,
    input  logic      excOccur_i,
    // toward memory
    input  logic      outAllowin_i,
    output logic      outValid_o,
    output exeOut_t   outData_o,
    output logic      outFlush_o,
    output logic      outHasRisk_o,
    // toward fetch
    output redirect_t redirect_o
);

    logic    exeValid;
    exeOut_t exeData;
    logic    amendAllowin;
    logic    amendFlush;
    logic    exeClear;

    // younger entry dies on either flush
    assign exeClear = amendFlush || excOccur_i;

    branchResolve resolve0 (
        .clk           (clk),
        .rstN_i        (rstN_i),
        .inValid_i     (inValid_i),
        .inData_i      (inData_i),
        .inAllowin_o   (inAllowin_o),
        .clear_i       (exeClear),
        .exeValid_o    (exeValid),
        .exeData_o     (exeData),
        .downAllowin_i (amendAllowin)
    );

    branchAmendStage amend0 (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .exeValid_i   (exeValid),
        .exeData_i    (exeData),
        .allowin_o    (amendAllowin),
        .memRisk_i    (memRisk_i),
        .excOccur_i   (excOccur_i),
        .outAllowin_i (outAllowin_i),
        .valid_o      (outValid_o),
        .data_o       (outData_o),
        .flush_o      (amendFlush),
        .hasRisk_o    (outHasRisk_o)
    );

    redirectControl redirect0 (
        .clk           (clk),
        .rstN_i        (rstN_i),
        .branchFlush_i (amendFlush),
        .amendData_i   (outData_o),
        .excOccur_i    (excOccur_i),
        .redirect_o    (redirect_o)
    );

    assign outFlush_o = amendFlush;

endmodule

//--- hw/branchResolve.sv
////////////////////////////////////////////////////////////////////////////
// upper execute stage: holds one entry, evaluates its branch condition
// and compares the outcome with the front end prediction
////////////////////////////////////////////////////////////////////////////
`include "branch_params.svh"

module branchResolve
    import branchTypesPkg::*;
    import pipeTypesPkg::*;
(
    input  logic    clk,
    input  logic    rstN_i,
    // upstream side
    input  logic    inValid_i,
    input  exeIn_t  inData_i,
    output logic    inAllowin_o,
    // squash of the held entry
    input  logic    clear_i,
    // downstream side
    output logic    exeValid_o,
    output exeOut_t exeData_o,
    input  logic    downAllowin_i
);

    ////////////////////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////////////////////
    logic   hasData;
    exeIn_t entry;

    assign inAllowin_o = !hasData || downAllowin_i;  // empty or leaving now
    assign exeValid_o  = hasData;

    always_ff @(posedge clk) begin
        if (!rstN_i || clear_i) begin
            hasData <= 1'b0;
        end else if (inAllowin_o) begin
            hasData <= inValid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (inAllowin_o && inValid_i) begin
            entry <= inData_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // branch evaluation on the held entry
    ////////////////////////////////////////////////////////////////////////////
    logic              condTake;
    logic              isBranch;
    logic              needRepair;
    logic              misaligned;
    logic [`XLEN-1:0]  brTarget;
    logic [`XLEN-1:0]  corrDest;

    always_comb begin
        unique case (entry.kind)
            EQ:      condTake = entry.rs1Val == entry.rs2Val;
            NE:      condTake = entry.rs1Val != entry.rs2Val;
            LT:      condTake = $signed(entry.rs1Val) < $signed(entry.rs2Val);
            GE:      condTake = $signed(entry.rs1Val) >= $signed(entry.rs2Val);
            LTU:     condTake = entry.rs1Val < entry.rs2Val;
            GEU:     condTake = entry.rs1Val >= entry.rs2Val;
            default: condTake = 1'b0;   // NONE falls through
        endcase
    end

    assign isBranch   = entry.kind != NONE;
    assign brTarget   = entry.pc + entry.offset;
    assign corrDest   = condTake ? brTarget : entry.pc + `XLEN'(`PC_STEP);
    assign misaligned = condTake && (brTarget[1:0] != 2'b00);

    // wrong direction, or right direction with a wrong taken target
    assign needRepair = isBranch && ((condTake != entry.predTake) ||
                                     (condTake && (entry.predDest != corrDest)));

    always_comb begin
        exeData_o.pc                = entry.pc;
        exeData_o.writeNum          = entry.writeNum;
        exeData_o.aluRes            = entry.aluRes;
        exeData_o.hasException      = misaligned;
        exeData_o.repair.needRepair = needRepair;
        exeData_o.repair.ckptId     = entry.ckptId;
        if (misaligned) begin
            exeData_o.info.excView.spare    = 1'b0;
            exeData_o.info.excView.excCode  = `EXC_MISALIGN;
            exeData_o.info.excView.badVAddr = brTarget;
        end else begin
            exeData_o.info.brView.corrTake = condTake;
            exeData_o.info.brView.corrDest = corrDest;
            exeData_o.info.brView.pad      = '0;
        end
    end

endmodule

//--- hw/branchTypesPkg.sv
////////////////////////////////////////////////////////////////////////////
// branch specific types: condition kind, repair action and the
// resolve-info word that is read either as a branch or as an exception
////////////////////////////////////////////////////////////////////////////
`include "branch_params.svh"

package branchTypesPkg;

    // condition evaluated in upper execute
    typedef enum logic [2:0] {
        NONE = 3'd0,    // not a branch
        EQ   = 3'd1,
        NE   = 3'd2,
        LT   = 3'd3,    // signed
        GE   = 3'd4,    // signed
        LTU  = 3'd5,
        GEU  = 3'd6
    } brKind_e;

    typedef struct packed {
        logic                   needRepair;  // front end must be redirected
        logic [`CKPT_BITS-1:0]  ckptId;      // checkpoint to restore
    } repairAction_t;

    // hasException beside this word picks the view
    typedef union packed {
        struct packed {
            logic                  corrTake;
            logic [`XLEN-1:0]      corrDest;
            logic [`EXC_BITS-1:0]  pad;       // unused in the branch view
        } brView;
        struct packed {
            logic                  spare;     // keeps both views equal width
            logic [`EXC_BITS-1:0]  excCode;
            logic [`XLEN-1:0]      badVAddr;
        } excView;
    } resolveInfo_u;

endpackage

//--- hw/pipeTypesPkg.sv
////////////////////////////////////////////////////////////////////////////
// payloads passed between the pipeline stages of the slice and the
// redirect handed back to the front end
////////////////////////////////////////////////////////////////////////////
`include "branch_params.svh"

package pipeTypesPkg;
    import branchTypesPkg::*;

    // entry arriving at upper execute
    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      rs1Val;
        logic [`XLEN-1:0]      rs2Val;
        logic [`XLEN-1:0]      offset;     // branch displacement
        brKind_e               kind;
        logic                  predTake;   // front end guess
        logic [`XLEN-1:0]      predDest;
        logic [`GPR_BITS-1:0]  writeNum;
        logic [`XLEN-1:0]      aluRes;
        logic [`CKPT_BITS-1:0] ckptId;
    } exeIn_t;

    // resolved entry, same shape in both confirmation stages
    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`GPR_BITS-1:0]  writeNum;
        logic [`XLEN-1:0]      aluRes;
        resolveInfo_u          info;
        logic                  hasException;  // selects excView
        repairAction_t         repair;
    } exeOut_t;

    typedef struct packed {
        logic                  valid;      // one cycle pulse
        logic                  isExc;
        logic [`XLEN-1:0]      target;
        logic [`CKPT_BITS-1:0] ckptId;
    } redirect_t;

endpackage

//--- hw/redirectControl.sv
////////////////////////////////////////////////////////////////////////////
// merges the exception flush and the branch flush into one registered
// front end redirect, exception first
////////////////////////////////////////////////////////////////////////////
`include "branch_params.svh"

module redirectControl
    import branchTypesPkg::*;
    import pipeTypesPkg::*;
(
    input  logic      clk,
    input  logic      rstN_i,
    input  logic      branchFlush_i,   // confirmed misprediction
    input  exeOut_t   amendData_i,     // entry causing the flush
    input  logic      excOccur_i,
    output redirect_t redirect_o
);

    logic                   validQ;
    logic                   isExcQ;
    logic [`XLEN-1:0]       targetQ;
    logic [`CKPT_BITS-1:0]  ckptQ;

    // control bits
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            validQ <= 1'b0;
            isExcQ <= 1'b0;
        end else begin
            validQ <= excOccur_i || branchFlush_i;  // single cycle pulse
            isExcQ <= excOccur_i;
        end
    end

    // destination and checkpoint
    always_ff @(posedge clk) begin
        if (excOccur_i) begin
            targetQ <= `EXC_VECTOR;
            ckptQ   <= '0;
        end else begin
            targetQ <= amendData_i.info.brView.corrDest;
            ckptQ   <= amendData_i.repair.ckptId;
        end
    end

    assign redirect_o = '{valid: validQ, isExc: isExcQ, target: targetQ, ckptId: ckptQ};

endmodule

//--- include/branch_params.svh
////////////////////////////////////////////////////////////////////////////
// widths and constants for the branch confirmation slice
// include wherever a width or a fixed code is needed
////////////////////////////////////////////////////////////////////////////
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// datapath
`define XLEN         32     // data and address width
`define GPR_BITS     5      // register number, 0 = no write-back
`define CKPT_BITS    4      // checkpoint id

// exception side
`define EXC_BITS     5
`define EXC_MISALIGN 5'h04  // branch target not word aligned
`define EXC_VECTOR   32'h8000_0180

// sequential fetch step
`define PC_STEP      4

`endif

//--- tests/amendChecker.sv
////////////////////////////////////////////////////////////////////////////
// reference model and scoreboard for the branch confirmation slice
// samples at the falling edge, compares every DUT output, counts errors
////////////////////////////////////////////////////////////////////////////
`include "branch_params.svh"

module amendChecker
    import branchTypesPkg::*;
    import pipeTypesPkg::*;
(
    input  logic      clk,
    input  logic      rstN_i,
    input  logic      inValid_i,
    input  exeIn_t    inData_i,
    input  logic      inAllowin_i,
    input  logic      memRisk_i,
    input  logic      excOccur_i,
    input  logic      outAllowin_i,
    input  logic      outValid_i,
    input  exeOut_t   outData_i,
    input  logic      outFlush_i,
    input  logic      outHasRisk_i,
    input  redirect_t redirect_i,
    output int        errCount_o,
    output int        inFlight_o,
    output int        accepted_o,
    output int        delivered_o,
    output int        dropped_o,
    output int        branchFlushes_o,
    output int        excFlushes_o
);

    exeIn_t    pending[$];   // accepted and still inside, oldest first
    logic      exeFull;
    logic      amendFull;
    redirect_t expRedir;     // redirect due one cycle later

    initial begin
        errCount_o = 0;
        inFlight_o = 0;
        accepted_o = 0;
        delivered_o = 0;
        dropped_o = 0;
        branchFlushes_o = 0;
        excFlushes_o = 0;
        exeFull = 1'b0;
        amendFull = 1'b0;
        expRedir = '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // branch rules
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic condHolds(input brKind_e kind, input logic [`XLEN-1:0] a,
                                       input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] biasA;
        logic [`XLEN-1:0] biasB;
        biasA = a ^ (`XLEN'(1) << (`XLEN-1));  // flipped sign bit, unsigned order = signed
        biasB = b ^ (`XLEN'(1) << (`XLEN-1));
        case (kind)
            EQ:      return a == b;
            NE:      return a != b;
            LT:      return biasA < biasB;
            GE:      return !(biasA < biasB);
            LTU:     return a < b;
            GEU:     return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic exeOut_t expectResolve(input exeIn_t e);
        exeOut_t          r;
        logic             taken;
        logic [`XLEN-1:0] target;
        logic [`XLEN-1:0] dest;
        taken  = condHolds(e.kind, e.rs1Val, e.rs2Val);
        target = e.pc + e.offset;
        dest   = taken ? target : e.pc + `PC_STEP;
        r = '0;
        r.pc       = e.pc;
        r.writeNum = e.writeNum;
        r.aluRes   = e.aluRes;
        r.repair.ckptId     = e.ckptId;
        r.repair.needRepair = (e.kind != NONE) &&
                              ((taken != e.predTake) || (taken && (e.predDest != dest)));
        if (taken && (target[1:0] != 2'b00)) begin
            r.hasException              = 1'b1;   // misaligned taken target
            r.info.excView.excCode      = `EXC_MISALIGN;
            r.info.excView.badVAddr     = target;
        end else begin
            r.info.brView.corrTake = taken;
            r.info.brView.corrDest = dest;
        end
        return r;
    endfunction

    task automatic compareValue(input string sigName, input logic [63:0] expVal,
                                input logic [63:0] actVal);
        if (actVal !== expVal) begin
            errCount_o = errCount_o + 1;
            $display("FAIL t=%0t %s expected %0h got %0h", $time, sigName, expVal, actVal);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // per cycle compare and occupancy update
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin : scoreboard
        exeOut_t expRes;
        logic    repairHeld;
        logic    stall;
        logic    expFlush;
        logic    expValid;
        logic    expRisk;
        logic    amendTake;
        logic    expInAllowin;
        logic    accept;
        if (!rstN_i) begin
            pending.delete();
            exeFull   = 1'b0;
            amendFull = 1'b0;
            expRedir  = '0;
        end else begin
            expRes       = amendFull ? expectResolve(pending[0]) : '0;
            repairHeld   = amendFull && expRes.repair.needRepair;
            stall        = memRisk_i && repairHeld;       // repair waits for memory
            expFlush     = repairHeld && !expRes.hasException && !memRisk_i;
            expValid     = amendFull && !stall && !excOccur_i && (outAllowin_i || expFlush);
            expRisk      = (amendFull && (expRes.hasException || expRes.repair.needRepair)) ||
                           memRisk_i;
            amendTake    = !amendFull || (!stall && outAllowin_i);
            expInAllowin = !exeFull || amendTake;
            accept       = inValid_i && expInAllowin;

            compareValue("inAllowin_o", expInAllowin, inAllowin_i);
            compareValue("outValid_o", expValid, outValid_i);
            compareValue("outFlush_o", expFlush, outFlush_i);
            compareValue("outHasRisk_o", expRisk, outHasRisk_i);
            if (amendFull) begin   // also holds while stalled
                compareValue("outData_o.pc", expRes.pc, outData_i.pc);
                compareValue("outData_o.writeNum", expRes.writeNum, outData_i.writeNum);
                compareValue("outData_o.aluRes", expRes.aluRes, outData_i.aluRes);
                compareValue("outData_o.info", expRes.info, outData_i.info);
                compareValue("outData_o.hasException", expRes.hasException,
                             outData_i.hasException);
                compareValue("outData_o.repair", expRes.repair, outData_i.repair);
            end
            compareValue("redirect_o.valid", expRedir.valid, redirect_i.valid);
            if (expRedir.valid) begin
                compareValue("redirect_o.isExc", expRedir.isExc, redirect_i.isExc);
                compareValue("redirect_o.target", expRedir.target, redirect_i.target);
                compareValue("redirect_o.ckptId", expRedir.ckptId, redirect_i.ckptId);
            end

            // exception first, then branch
            expRedir = '0;
            if (excOccur_i) begin
                expRedir.valid  = 1'b1;
                expRedir.isExc  = 1'b1;
                expRedir.target = `EXC_VECTOR;
            end else if (expFlush) begin
                expRedir.valid  = 1'b1;
                expRedir.target = expRes.info.brView.corrDest;
                expRedir.ckptId = expRes.repair.ckptId;
            end

            if (accept) accepted_o = accepted_o + 1;
            if (excOccur_i) begin             // both stages and the new input die
                dropped_o    = dropped_o + pending.size() + int'(accept);
                excFlushes_o = excFlushes_o + 1;
                pending.delete();
                exeFull   = 1'b0;
                amendFull = 1'b0;
            end else if (expFlush) begin      // flusher leaves, younger ones die
                delivered_o     = delivered_o + 1;
                dropped_o       = dropped_o + pending.size() - 1 + int'(accept);
                branchFlushes_o = branchFlushes_o + 1;
                pending.delete();
                exeFull   = 1'b0;
                amendFull = 1'b0;
            end else begin
                if (expValid) begin
                    void'(pending.pop_front());
                    delivered_o = delivered_o + 1;
                end
                if (amendTake) amendFull = exeFull;
                if (expInAllowin) begin
                    exeFull = inValid_i;
                    if (inValid_i) pending.push_back(inData_i);
                end
            end
        end
        inFlight_o = pending.size();
    end

endmodule

//--- tests/tbBranchAmend.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the branch confirmation slice
// random entries and random stalls, risks and exceptions from a fixed seed
////////////////////////////////////////////////////////////////////////////

module tbBranchAmend
    import branchTypesPkg::*;
    import pipeTypesPkg::*;
();

    localparam int NUM_CYCLES  = 4000;
    localparam int DRAIN_LIMIT = 100;   // cycles allowed to empty the pipe

    logic      clk;
    logic      rstN;
    logic      inValid;
    exeIn_t    inData;
    logic      inAllowin;
    logic      memRisk;
    logic      excOccur;
    logic      outAllowin;
    logic      outValid;
    exeOut_t   outData;
    logic      outFlush;
    logic      outHasRisk;
    redirect_t redirect;

    int errCount;
    int inFlight;
    int accepted;
    int delivered;
    int dropped;
    int branchFlushes;
    int excFlushes;
    int tbErrors;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    branchAmendTop dut0 (
        .clk          (clk),
        .rstN_i       (rstN),
        .inValid_i    (inValid),
        .inData_i     (inData),
        .inAllowin_o  (inAllowin),
        .memRisk_i    (memRisk),
        .excOccur_i   (excOccur),
        .outAllowin_i (outAllowin),
        .outValid_o   (outValid),
        .outData_o    (outData),
        .outFlush_o   (outFlush),
        .outHasRisk_o (outHasRisk),
        .redirect_o   (redirect)
    );

    amendChecker chk0 (
        .clk             (clk),
        .rstN_i          (rstN),
        .inValid_i       (inValid),
        .inData_i        (inData),
        .inAllowin_i     (inAllowin),
        .memRisk_i       (memRisk),
        .excOccur_i      (excOccur),
        .outAllowin_i    (outAllowin),
        .outValid_i      (outValid),
        .outData_i       (outData),
        .outFlush_i      (outFlush),
        .outHasRisk_i    (outHasRisk),
        .redirect_i      (redirect),
        .errCount_o      (errCount),
        .inFlight_o      (inFlight),
        .accepted_o      (accepted),
        .delivered_o     (delivered),
        .dropped_o       (dropped),
        .branchFlushes_o (branchFlushes),
        .excFlushes_o    (excFlushes)
    );

    // small operands so EQ hits and mostly right target guesses
    function automatic exeIn_t randomEntry();
        exeIn_t e;
        e.pc     = $urandom & 32'h0000_fffc;
        e.rs1Val = ($urandom_range(0, 1) != 0) ? $urandom_range(0, 3) : $urandom;
        e.rs2Val = ($urandom_range(0, 1) != 0) ? $urandom_range(0, 3) : $urandom;
        e.offset = $urandom & 32'h0000_03fc;
        if ($urandom_range(0, 1) != 0) e.offset = -e.offset;   // backward branch
        if ($urandom_range(0, 7) == 0) e.offset[1:0] = $urandom_range(1, 3);
        e.kind     = brKind_e'($urandom_range(0, 6));
        e.predTake = $urandom_range(0, 1);
        e.predDest = ($urandom_range(0, 3) != 0) ? e.pc + e.offset : $urandom;
        e.writeNum = $urandom;
        e.aluRes   = $urandom;
        e.ckptId   = $urandom;
        return e;
    endfunction

    initial begin : stimulus
        int   drainWait;
        logic offerTaken;
        void'($urandom(32'h8c98));
        tbErrors   = 0;
        rstN       = 1'b0;
        inValid    = 1'b0;
        inData     = '0;
        memRisk    = 1'b0;
        excOccur   = 1'b0;
        outAllowin = 1'b1;
        repeat (8) @(posedge clk);
        #1 rstN = 1'b1;

        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(negedge clk);
            offerTaken = inValid && inAllowin;
            @(posedge clk);
            #1;
            if (!inValid || offerTaken) begin   // hold an offer until it is taken
                inValid = ($urandom_range(0, 3) != 0);
                inData  = randomEntry();
            end
            outAllowin = ($urandom_range(0, 3) != 0);
            memRisk    = ($urandom_range(0, 4) == 0);
            excOccur   = ($urandom_range(0, 39) == 0);
        end

        // drain
        @(posedge clk);
        #1;
        inValid    = 1'b0;
        memRisk    = 1'b0;
        excOccur   = 1'b0;
        outAllowin = 1'b1;
        drainWait  = 0;
        while (inFlight != 0 && drainWait < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            drainWait++;
        end
        if (inFlight != 0) begin
            $display("timeout: %0d entries still inside after %0d drain cycles",
                     inFlight, DRAIN_LIMIT);
            tbErrors++;
        end
        repeat (4) @(posedge clk);   // last redirect gets compared
        if (delivered == 0 || branchFlushes == 0 || excFlushes == 0) begin
            $display("stimulus never produced a delivery, a branch flush and an exception");
            tbErrors++;
        end

        $display("errors %0d (checker %0d, testbench %0d) accepted %0d delivered %0d %s%0d",
                 errCount + tbErrors, errCount, tbErrors, accepted, delivered,
                 "dropped ", dropped);
        if (errCount + tbErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
